//--- Bender.yml
package:
  name: command_unit

sources:
  # rtl
  - files:
      - hw/capi_pkg.sv
      - hw/cmd_pkg.sv
      - hw/sync_fifo.sv
      - hw/cmd_arbiter.sv
      - hw/credit_tracker.sv
      - hw/cmd_issue.sv
      - hw/resp_router.sv
      - hw/command_unit.sv
  # tb
  - target: tb
    files:
      - tb/tb_command_unit.sv

//--- hw/capi_pkg.sv
`default_nettype none

package capi_pkg;

	////////////////////
	// Tag layout
	////////////////////

	// Class field sits in the top bits of the tag
	localparam int TAG_W   = 8;
	localparam int CLASS_W = 2;
	localparam int SEQ_W   = 6;

	// Credits returned per response
	localparam int RESP_CREDIT_W = 4;

	////////////////////
	// Opcodes and codes
	////////////////////

	// Bus command opcodes, short forms of the host encodings
	typedef enum logic [7:0] {
		CMD_READ_CL  = 8'h0A,
		CMD_WRITE_MI = 8'h0D,
		CMD_RESTART  = 8'h01
	} capi_cmd_e;

	// Completion codes
	typedef enum logic [7:0] {
		RESP_DONE   = 8'h00,
		RESP_AERROR = 8'h01,
		RESP_DERROR = 8'h03,
		RESP_FAILED = 8'h08
	} capi_resp_e;

	////////////////////
	// Bus-side structs
	////////////////////

	// Command to the host, 57 bits
	typedef struct packed {
		logic             valid;
		capi_cmd_e        opcode;
		logic [TAG_W-1:0] tag;
		logic [31:0]      address;
		logic [7:0]       size;
	} capi_command_t;

	// Response from the host, 21 bits
	typedef struct packed {
		logic                     valid;
		logic [TAG_W-1:0]         tag;
		capi_resp_e               code;
		logic [RESP_CREDIT_W-1:0] credits;
	} capi_response_t;

endpackage

`default_nettype wire

//--- hw/cmd_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_arbiter
	import capi_pkg::*;
	import cmd_pkg::*;
(
	input  logic                   clock,
	input  logic                   arst_n,
	input  logic                   enabled,
	input  logic                   credits_avail,
	input  cmd_line_t              read_head,
	input  cmd_line_t              write_head,
	input  cmd_line_t              restart_head,
	input  logic [NUM_CLASSES-1:0] empties,
	output logic [NUM_CLASSES-1:0] pops,
	output logic                   grant_valid,
	output cmd_class_e             grant_class,
	output cmd_line_t              grant_line
);

	logic [NUM_CLASSES-1:0] req;
	logic [CLASS_W-1:0]     ptr;
	logic [CLASS_W-1:0]     grant_idx;

	// Class index plus offset, modulo the class count
	function automatic logic [CLASS_W-1:0] rot(input logic [CLASS_W-1:0] base,
	                                           input int unsigned off);
		int unsigned sum;
		sum = base + off;
		if (sum >= NUM_CLASSES)
			sum = sum - NUM_CLASSES;
		return CLASS_W'(sum);
	endfunction

	// Requests only while enabled and credits remain
	assign req = ~empties & {NUM_CLASSES{enabled && credits_avail}};

	// First request at or after the pointer
	// Far offsets first so the nearest one wins
	always_comb begin
		grant_valid = 1'b0;
		grant_idx   = ptr;
		for (int i = NUM_CLASSES - 1; i >= 0; i--) begin
			if (req[rot(ptr, i)]) begin
				grant_valid = 1'b1;
				grant_idx   = rot(ptr, i);
			end
		end
	end

	assign grant_class = cmd_class_e'(grant_idx);

	// One-hot pop, same cycle as the grant
	always_comb begin
		pops = '0;
		if (grant_valid)
			pops[grant_idx] = 1'b1;
	end

	// Head of the chosen buffer
	always_comb begin
		case (grant_class)
			CLASS_READ:  grant_line = read_head;
			CLASS_WRITE: grant_line = write_head;
			default:     grant_line = restart_head;
		endcase
	end

	// Round-robin pointer, moves past the winner
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			ptr <= CLASS_READ;
		else if (grant_valid)
			ptr <= rot(grant_idx, 1);
	end

endmodule

`default_nettype wire

//--- hw/cmd_issue.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_issue
	import capi_pkg::*;
	import cmd_pkg::*;
(
	input  logic          clock,
	input  logic          arst_n,
	input  logic          grant_valid,
	input  cmd_class_e    grant_class,
	input  cmd_line_t     grant_line,
	output capi_command_t command_out,
	output logic          issue
);

	logic             cmd_valid;
	logic [SEQ_W-1:0] seq;

	// Payload registers
	capi_cmd_e        op_q;
	logic [TAG_W-1:0] tag_q;
	logic [31:0]      addr_q;
	logic [7:0]       size_q;

	// Valid strobe and sequence counter
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			cmd_valid <= 1'b0;
			seq       <= '0;
		end else begin
			cmd_valid <= grant_valid;
			if (grant_valid)
				seq <= seq + 1'b1;
		end
	end

	// Tag is class on top, sequence below
	always_ff @(posedge clock) begin
		if (grant_valid) begin
			op_q   <= grant_line.opcode;
			tag_q  <= {grant_class, seq};
			addr_q <= grant_line.address;
			size_q <= grant_line.size;
		end
	end

	always_comb begin
		command_out.valid   = cmd_valid;
		command_out.opcode  = op_q;
		command_out.tag     = tag_q;
		command_out.address = addr_q;
		command_out.size    = size_q;
	end

	// Credit spent when the command leaves
	assign issue = cmd_valid;

endmodule

`default_nettype wire

//--- hw/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

	import capi_pkg::*;

	////////////////////
	// Client classes
	////////////////////

	// Class value 3 is undefined, seen only as a bad tag
	typedef enum logic [CLASS_W-1:0] {
		CLASS_READ    = CLASS_W'(0),
		CLASS_WRITE   = CLASS_W'(1),
		CLASS_RESTART = CLASS_W'(2)
	} cmd_class_e;

	localparam int NUM_CLASSES = 3;

	////////////////////
	// Buffer lines
	////////////////////

	// Client command, no tag yet, 49 bits
	typedef struct packed {
		logic        valid;
		capi_cmd_e   opcode;
		logic [31:0] address;
		logic [7:0]  size;
	} cmd_line_t;

	// Routed response, 17 bits
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		capi_resp_e       code;
	} resp_line_t;

	// Per buffer status
	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
	} buf_status_t;

	typedef struct packed {
		buf_status_t read;
		buf_status_t write;
		buf_status_t restart;
	} cmd_status_t;

	////////////////////
	// Sizes and credits
	////////////////////

	localparam int READ_DEPTH    = 16;
	localparam int WRITE_DEPTH   = 16;
	localparam int RESTART_DEPTH = 2;

	localparam int INITIAL_CREDITS = 4;
	localparam int CREDIT_W        = 5;

	// Sticky error bit positions
	localparam int ERR_W       = 4;
	localparam int ERR_AERROR  = 0;
	localparam int ERR_DERROR  = 1;
	localparam int ERR_FAILED  = 2;
	localparam int ERR_BAD_TAG = 3;

endpackage

`default_nettype wire

//--- hw/command_unit.sv
`timescale 1ns/1ns
`default_nettype none

module command_unit
	import capi_pkg::*;
	import cmd_pkg::*;
(
	input  logic             clock,
	input  logic             arst_n,
	input  logic             enabled,
	input  cmd_line_t        read_cmd_in,
	input  cmd_line_t        write_cmd_in,
	input  cmd_line_t        restart_cmd_in,
	input  capi_response_t   response,
	output capi_command_t    command_out,
	output resp_line_t       read_resp_out,
	output resp_line_t       write_resp_out,
	output resp_line_t       restart_resp_out,
	output cmd_status_t      cmd_status,
	output logic [ERR_W-1:0] response_error
);

	// Command buffer heads
	cmd_line_t read_head;
	cmd_line_t write_head;
	cmd_line_t restart_head;

	logic [NUM_CLASSES-1:0] cmd_pops;
	logic [NUM_CLASSES-1:0] cmd_empties;

	logic       grant_valid;
	cmd_class_e grant_class;
	cmd_line_t  grant_line;
	logic       issue;
	logic       credits_avail;

	// Router to response buffers
	logic       read_push;
	logic       write_push;
	logic       restart_push;
	resp_line_t routed_line;

	resp_line_t read_resp_q;
	resp_line_t write_resp_q;
	resp_line_t restart_resp_q;
	logic       read_resp_empty;
	logic       write_resp_empty;
	logic       restart_resp_empty;

	////////////////////
	// Command buffers
	////////////////////

	sync_fifo #(.WIDTH($bits(cmd_line_t)), .DEPTH(READ_DEPTH)) read_cmd_fifo_instant (
		.clock(clock), .arst_n(arst_n),
		.push(read_cmd_in.valid), .data_in(read_cmd_in),
		.pop(cmd_pops[CLASS_READ]), .data_out(read_head),
		.full(cmd_status.read.full), .alfull(cmd_status.read.alfull),
		.empty(cmd_status.read.empty)
	);

	sync_fifo #(.WIDTH($bits(cmd_line_t)), .DEPTH(WRITE_DEPTH)) write_cmd_fifo_instant (
		.clock(clock), .arst_n(arst_n),
		.push(write_cmd_in.valid), .data_in(write_cmd_in),
		.pop(cmd_pops[CLASS_WRITE]), .data_out(write_head),
		.full(cmd_status.write.full), .alfull(cmd_status.write.alfull),
		.empty(cmd_status.write.empty)
	);

	sync_fifo #(.WIDTH($bits(cmd_line_t)), .DEPTH(RESTART_DEPTH)) restart_cmd_fifo_instant (
		.clock(clock), .arst_n(arst_n),
		.push(restart_cmd_in.valid), .data_in(restart_cmd_in),
		.pop(cmd_pops[CLASS_RESTART]), .data_out(restart_head),
		.full(cmd_status.restart.full), .alfull(cmd_status.restart.alfull),
		.empty(cmd_status.restart.empty)
	);

	// Indexed by class
	assign cmd_empties = {cmd_status.restart.empty, cmd_status.write.empty,
	                      cmd_status.read.empty};

	////////////////////
	// Arbiter, credits, issue
	////////////////////

	cmd_arbiter cmd_arbiter_instant (
		.clock(clock), .arst_n(arst_n),
		.enabled(enabled), .credits_avail(credits_avail),
		.read_head(read_head), .write_head(write_head), .restart_head(restart_head),
		.empties(cmd_empties), .pops(cmd_pops),
		.grant_valid(grant_valid), .grant_class(grant_class), .grant_line(grant_line)
	);

	credit_tracker credit_tracker_instant (
		.clock(clock), .arst_n(arst_n),
		.issue(issue), .resp_valid(response.valid), .resp_credits(response.credits),
		.credits_avail(credits_avail)
	);

	cmd_issue cmd_issue_instant (
		.clock(clock), .arst_n(arst_n),
		.grant_valid(grant_valid), .grant_class(grant_class), .grant_line(grant_line),
		.command_out(command_out), .issue(issue)
	);

	////////////////////
	// Responses
	////////////////////

	resp_router resp_router_instant (
		.clock(clock), .arst_n(arst_n), .response(response),
		.read_push(read_push), .write_push(write_push), .restart_push(restart_push),
		.line(routed_line), .response_error(response_error)
	);

	// Response buffers drain whenever not empty
	sync_fifo #(.WIDTH($bits(resp_line_t)), .DEPTH(READ_DEPTH)) read_resp_fifo_instant (
		.clock(clock), .arst_n(arst_n),
		.push(read_push), .data_in(routed_line),
		.pop(!read_resp_empty), .data_out(read_resp_q),
		.full(), .alfull(), .empty(read_resp_empty)
	);

	sync_fifo #(.WIDTH($bits(resp_line_t)), .DEPTH(WRITE_DEPTH)) write_resp_fifo_instant (
		.clock(clock), .arst_n(arst_n),
		.push(write_push), .data_in(routed_line),
		.pop(!write_resp_empty), .data_out(write_resp_q),
		.full(), .alfull(), .empty(write_resp_empty)
	);

	sync_fifo #(.WIDTH($bits(resp_line_t)), .DEPTH(RESTART_DEPTH)) restart_resp_fifo_instant (
		.clock(clock), .arst_n(arst_n),
		.push(restart_push), .data_in(routed_line),
		.pop(!restart_resp_empty), .data_out(restart_resp_q),
		.full(), .alfull(), .empty(restart_resp_empty)
	);

	// Outgoing valid only while an entry is at the head
	always_comb begin
		read_resp_out          = read_resp_q;
		read_resp_out.valid    = read_resp_q.valid && !read_resp_empty;
		write_resp_out         = write_resp_q;
		write_resp_out.valid   = write_resp_q.valid && !write_resp_empty;
		restart_resp_out       = restart_resp_q;
		restart_resp_out.valid = restart_resp_q.valid && !restart_resp_empty;
	end

endmodule

`default_nettype wire

//--- hw/credit_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module credit_tracker
	import capi_pkg::*;
	import cmd_pkg::*;
(
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     issue,
	input  logic                     resp_valid,
	input  logic [RESP_CREDIT_W-1:0] resp_credits,
	output logic                     credits_avail
);

	localparam logic [CREDIT_W:0] CREDIT_MAX = {1'b0, {CREDIT_W{1'b1}}};

	logic [CREDIT_W-1:0] count;
	logic [CREDIT_W:0]   returned;
	logic [CREDIT_W:0]   next_count;

	// Return and decrement may land in the same cycle
	always_comb begin
		returned   = resp_valid ? (CREDIT_W + 1)'(resp_credits) : '0;
		next_count = {1'b0, count} + returned - (CREDIT_W + 1)'(issue);
		// Saturate at the counter width
		if (next_count > CREDIT_MAX)
			next_count = CREDIT_MAX;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			count <= CREDIT_W'(INITIAL_CREDITS);
		else
			count <= next_count[CREDIT_W-1:0];
	end

	// Count net of the command leaving this cycle
	// Keeps a grant from spending a credit already used
	assign credits_avail = (count > CREDIT_W'(issue));

endmodule

`default_nettype wire

//--- hw/resp_router.sv
`timescale 1ns/1ns
`default_nettype none

module resp_router
	import capi_pkg::*;
	import cmd_pkg::*;
(
	input  logic             clock,
	input  logic             arst_n,
	input  capi_response_t   response,
	output logic             read_push,
	output logic             write_push,
	output logic             restart_push,
	output resp_line_t       line,
	output logic [ERR_W-1:0] response_error
);

	logic               valid_q;
	logic [TAG_W-1:0]   tag_q;
	capi_resp_e         code_q;
	logic [CLASS_W-1:0] class_q;
	logic [ERR_W-1:0]   new_err;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= response.valid;
	end

	// Tag and code, no reset
	always_ff @(posedge clock) begin
		if (response.valid) begin
			tag_q  <= response.tag;
			code_q <= response.code;
		end
	end

	////////////////////
	// Class decode
	////////////////////

	assign class_q = tag_q[TAG_W-1 -: CLASS_W];

	// Class 3 pushes nothing
	assign read_push    = valid_q && (class_q == CLASS_READ);
	assign write_push   = valid_q && (class_q == CLASS_WRITE);
	assign restart_push = valid_q && (class_q == CLASS_RESTART);

	always_comb begin
		line.valid = valid_q;
		line.tag   = tag_q;
		line.code  = code_q;
	end

	////////////////////
	// Sticky errors
	////////////////////

	always_comb begin
		new_err = '0;
		if (valid_q) begin
			case (code_q)
				RESP_AERROR: new_err[ERR_AERROR] = 1'b1;
				RESP_DERROR: new_err[ERR_DERROR] = 1'b1;
				RESP_FAILED: new_err[ERR_FAILED] = 1'b1;
				default:     new_err = '0;
			endcase
			// Undefined class in the tag
			if (class_q == CLASS_W'(NUM_CLASSES))
				new_err[ERR_BAD_TAG] = 1'b1;
		end
	end

	// Cleared by reset only
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			response_error <= '0;
		else
			response_error <= response_error | new_err;
	end

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             arst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Storage, no reset
	logic [WIDTH-1:0] mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic do_push;
	logic do_pop;

	// Ignore push on full, pop on empty
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Show-ahead head entry
	assign data_out = mem[rd_ptr];

	assign full   = (count == CNT_W'(DEPTH));
	assign alfull = (count == CNT_W'(DEPTH - 1));
	assign empty  = (count == '0);

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// Pointers wrap at DEPTH, not a power of two in general
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Occupancy
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_command_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_command_unit
	import capi_pkg::*;
	import cmd_pkg::*;
();

	// Commands per phase
	localparam int WARM_CMDS   = 12;
	localparam int RANDOM_CMDS = 40;
	localparam int HOLD_CMDS   = 8;
	localparam int NUM_CMDS    = WARM_CMDS + RANDOM_CMDS + HOLD_CMDS;
	localparam int CYCLE_LIMIT = 20 * NUM_CMDS + 200;

	logic             clock;
	logic             arst_n;
	logic             enabled;
	cmd_line_t        read_cmd_in;
	cmd_line_t        write_cmd_in;
	cmd_line_t        restart_cmd_in;
	capi_response_t   response;
	capi_command_t    command_out;
	resp_line_t       read_resp_out;
	resp_line_t       write_resp_out;
	resp_line_t       restart_resp_out;
	cmd_status_t      cmd_status;
	logic [ERR_W-1:0] response_error;

	integer seed;
	int     errors;
	int     cycles;
	int     pushed;
	int     issued;
	int     returned;
	int     hold_issued;
	int     resp_count;
	int     host_wait;
	int     last_cls;
	bit     last_pushed;

	// Phase flags driven by the main sequence
	logic quiet;
	logic host_hold;
	logic bad_request;
	logic bad_sent;
	logic end_phase;

	// Per class reference queues and the host's tag list
	cmd_line_t        read_q[$];
	cmd_line_t        write_q[$];
	cmd_line_t        restart_q[$];
	logic [TAG_W-1:0] host_q[$];

	// Monitor state
	logic             enabled_d;
	logic [2:0]       empty_d;
	logic [2:0]       push_d;
	logic [SEQ_W-1:0] next_seq;
	int               skip [3];
	int               occ [3];
	capi_response_t   resp_d1;
	capi_response_t   resp_d2;
	logic [ERR_W-1:0] err_model;

	// Check registers written at negedge and asserted at posedge
	logic             quiet_chk;
	logic [7:0]       quiet_val;
	logic             dis_chk;
	logic             cmd_chk;
	logic             cmd_orphan;
	logic [47:0]      cmd_got;
	logic [47:0]      cmd_exp;
	logic [SEQ_W-1:0] seq_got;
	logic [SEQ_W-1:0] seq_exp;
	int               outstanding;
	logic             hold_vio;
	logic [50:0]      resp_got_all;
	logic [50:0]      resp_exp_all;
	logic [ERR_W-1:0] err_got;
	logic [ERR_W-1:0] err_exp;
	cmd_status_t      status_got;
	cmd_status_t      status_exp;
	int               max_skip;
	logic             end_chk;
	logic [ERR_W-1:0] err_final;

	command_unit UUT (
		.clock(clock),
		.arst_n(arst_n),
		.enabled(enabled),
		.read_cmd_in(read_cmd_in),
		.write_cmd_in(write_cmd_in),
		.restart_cmd_in(restart_cmd_in),
		.response(response),
		.command_out(command_out),
		.read_resp_out(read_resp_out),
		.write_resp_out(write_resp_out),
		.restart_resp_out(restart_resp_out),
		.cmd_status(cmd_status),
		.response_error(response_error)
	);

	always #20 clock = ~clock;

	////////////////////
	// Helpers
	////////////////////

	task automatic value_error(input string name, input logic [63:0] got,
	                           input logic [63:0] exp);
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors++;
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic event_error(input string msg);
		$display("Error: %s", msg);
		errors++;
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	function automatic capi_cmd_e class_opcode(input int cls);
		case (cls)
			0: return CMD_READ_CL;
			1: return CMD_WRITE_MI;
			default: return CMD_RESTART;
		endcase
	endfunction

	// A few error codes among mostly DONE
	function automatic capi_resp_e response_code(input int index);
		case (index)
			3: return RESP_AERROR;
			7: return RESP_DERROR;
			11: return RESP_FAILED;
			default: return RESP_DONE;
		endcase
	endfunction

	// Room left counting a push still in flight from last cycle
	function automatic bit has_room(input int cls);
		buf_status_t st;
		if (cls == 0)
			st = cmd_status.read;
		else if (cls == 1)
			st = cmd_status.write;
		else
			st = cmd_status.restart;
		if (st.full)
			return 1'b0;
		if (st.alfull && last_pushed && last_cls == cls)
			return 1'b0;
		return 1'b1;
	endfunction

	// Flags of a buffer that holds n entries
	function automatic buf_status_t status_for(input int n, input int depth);
		buf_status_t s;
		s.full   = (n == depth);
		s.alfull = (n == depth - 1);
		s.empty  = (n == 0);
		return s;
	endfunction

	// What a class output should carry for a response two cycles back
	function automatic resp_line_t expected_line(input capi_response_t r, input int cls);
		resp_line_t l;
		l = '0;
		if (r.valid && int'(r.tag[TAG_W-1 -: CLASS_W]) == cls) begin
			l.valid = 1'b1;
			l.tag   = r.tag;
			l.code  = r.code;
		end
		return l;
	endfunction

	function automatic resp_line_t visible_line(input resp_line_t l);
		return l.valid ? l : '0;
	endfunction

	task automatic push_commands(input int n, input bit reads_only);
		int        done;
		int        cls;
		bit        room;
		cmd_line_t line;
		done = 0;
		while (done < n) begin
			@(negedge clock);
			if (reads_only)
				cls = 0;
			else
				cls = $unsigned($random(seed)) % 3;
			room         = has_room(cls);
			line.valid   = 1'b1;
			line.opcode  = class_opcode(cls);
			line.address = $random(seed);
			line.size    = 8'($random(seed));
			@(posedge clock);
			read_cmd_in    <= '0;
			write_cmd_in   <= '0;
			restart_cmd_in <= '0;
			last_pushed = room;
			last_cls    = cls;
			if (room) begin
				case (cls)
					0: begin
						read_cmd_in <= line;
						read_q.push_back(line);
					end
					1: begin
						write_cmd_in <= line;
						write_q.push_back(line);
					end
					default: begin
						restart_cmd_in <= line;
						restart_q.push_back(line);
					end
				endcase
				done++;
				pushed++;
			end
		end
		// Strobes last one cycle
		@(posedge clock);
		read_cmd_in    <= '0;
		write_cmd_in   <= '0;
		restart_cmd_in <= '0;
		last_pushed = 1'b0;
	endtask

	////////////////////
	// Host model
	////////////////////

	always @(posedge clock) begin : host_model
		capi_response_t rsp;
		rsp = '0;
		if (host_wait > 0) begin
			host_wait--;
		end else if (bad_request && !bad_sent) begin
			// Class 3 tag with no credit back
			rsp.valid   = 1'b1;
			rsp.tag     = {2'b11, 6'h15};
			rsp.code    = RESP_DONE;
			rsp.credits = '0;
			bad_sent <= 1'b1;
		end else if (!host_hold && host_q.size() > 0) begin
			rsp.valid   = 1'b1;
			rsp.tag     = host_q.pop_front();
			rsp.code    = response_code(resp_count);
			rsp.credits = 4'd1;
			resp_count++;
			host_wait = $unsigned($random(seed)) % 5;
		end
		response <= rsp;
	end

	////////////////////
	// Monitor
	////////////////////

	// Samples mid-cycle where everything is stable
	always @(negedge clock) begin : monitor
		int               cls;
		bit               orphan;
		cmd_line_t        exp_line;
		logic [ERR_W-1:0] new_err;
		int               top;
		if (arst_n) begin
			quiet_chk <= quiet;
			quiet_val <= {command_out.valid, read_resp_out.valid, write_resp_out.valid,
			              restart_resp_out.valid, response_error};
			// Grant was last cycle, so compare with last cycle's enable
			dis_chk   <= command_out.valid && !enabled_d;
			enabled_d = enabled;

			cls = 3;
			cmd_chk <= command_out.valid;
			if (command_out.valid) begin
				cls      = int'(command_out.tag[TAG_W-1 -: CLASS_W]);
				orphan   = 1'b0;
				exp_line = '0;
				case (cls)
					0: begin
						if (read_q.size() > 0)
							exp_line = read_q.pop_front();
						else
							orphan = 1'b1;
					end
					1: begin
						if (write_q.size() > 0)
							exp_line = write_q.pop_front();
						else
							orphan = 1'b1;
					end
					2: begin
						if (restart_q.size() > 0)
							exp_line = restart_q.pop_front();
						else
							orphan = 1'b1;
					end
					default: orphan = 1'b1;
				endcase
				cmd_orphan <= orphan;
				cmd_got <= {command_out.opcode, command_out.address, command_out.size};
				cmd_exp <= {exp_line.opcode, exp_line.address, exp_line.size};
				seq_got <= command_out.tag[SEQ_W-1:0];
				seq_exp <= next_seq;
				next_seq = next_seq + 1'b1;
				host_q.push_back(command_out.tag);
				issued++;
				// Nothing more may leave once the credits are spent
				if (host_hold) begin
					if (hold_issued >= INITIAL_CREDITS)
						hold_vio <= 1'b1;
					hold_issued++;
				end
			end
			if (response.valid)
				returned += int'(response.credits);
			outstanding <= issued - returned;

			// Waiting time per class in issues of other classes
			top = 0;
			for (int k = 0; k < 3; k++) begin
				if ((command_out.valid && cls == k) || empty_d[k])
					skip[k] = 0;
				else if (command_out.valid)
					skip[k]++;
				if (skip[k] > top)
					top = skip[k];
			end
			max_skip <= top;
			empty_d = {cmd_status.restart.empty, cmd_status.write.empty,
			           cmd_status.read.empty};

			// Buffer occupancy
			// A strobe lands at the next edge, a pop one cycle before its command
			for (int k = 0; k < 3; k++) begin
				if (push_d[k])
					occ[k]++;
				if (command_out.valid && cls == k)
					occ[k]--;
			end
			status_got <= cmd_status;
			status_exp <= {status_for(occ[0], READ_DEPTH), status_for(occ[1], WRITE_DEPTH),
			               status_for(occ[2], RESTART_DEPTH)};
			push_d = {restart_cmd_in.valid, write_cmd_in.valid, read_cmd_in.valid};

			// Response path with two cycles of latency
			resp_exp_all <= {expected_line(resp_d2, 2), expected_line(resp_d2, 1),
			                 expected_line(resp_d2, 0)};
			resp_got_all <= {visible_line(restart_resp_out), visible_line(write_resp_out),
			                 visible_line(read_resp_out)};
			new_err = '0;
			if (resp_d2.valid) begin
				if (resp_d2.code == RESP_AERROR)
					new_err[ERR_AERROR] = 1'b1;
				if (resp_d2.code == RESP_DERROR)
					new_err[ERR_DERROR] = 1'b1;
				if (resp_d2.code == RESP_FAILED)
					new_err[ERR_FAILED] = 1'b1;
				if (resp_d2.tag[TAG_W-1 -: CLASS_W] == 2'd3)
					new_err[ERR_BAD_TAG] = 1'b1;
			end
			err_model = err_model | new_err;
			err_got <= response_error;
			err_exp <= err_model;
			resp_d2 = resp_d1;
			resp_d1 = response;

			end_chk   <= end_phase;
			err_final <= response_error;
		end
	end

	////////////////////
	// Checks
	////////////////////

	assert property (@(posedge clock) disable iff (!arst_n) !quiet_chk || quiet_val == '0)
		else value_error("command_out.valid/resp_out valids/response_error", quiet_val, 0);
	assert property (@(posedge clock) disable iff (!arst_n) !dis_chk)
		else value_error("command_out.valid while disabled", 1, 0);
	assert property (@(posedge clock) disable iff (!arst_n) !cmd_chk || !cmd_orphan)
		else event_error("a command left with no pushed command left for its class");
	assert property (@(posedge clock) disable iff (!arst_n)
		!cmd_chk || cmd_orphan || cmd_got == cmd_exp)
		else value_error("command_out opcode/address/size", cmd_got, cmd_exp);
	assert property (@(posedge clock) disable iff (!arst_n) !cmd_chk || seq_got == seq_exp)
		else value_error("command_out.tag sequence", seq_got, seq_exp);
	assert property (@(posedge clock) disable iff (!arst_n) outstanding <= INITIAL_CREDITS)
		else event_error($sformatf("%0d commands outstanding with only %0d credits",
		                           outstanding, INITIAL_CREDITS));
	assert property (@(posedge clock) disable iff (!arst_n) !hold_vio)
		else event_error("a command left after all credits were spent");
	assert property (@(posedge clock) disable iff (!arst_n) resp_got_all == resp_exp_all)
		else value_error("restart/write/read_resp_out", resp_got_all, resp_exp_all);
	assert property (@(posedge clock) disable iff (!arst_n) err_got == err_exp)
		else value_error("response_error", err_got, err_exp);
	assert property (@(posedge clock) disable iff (!arst_n) status_got == status_exp)
		else value_error("cmd_status", status_got, status_exp);
	assert property (@(posedge clock) disable iff (!arst_n) max_skip <= 2)
		else event_error($sformatf("a class waited through %0d issues of other classes",
		                           max_skip));
	assert property (@(posedge clock) disable iff (!arst_n) !end_chk || err_final == 4'hF)
		else value_error("response_error at end", err_final, 4'hF);

	// Run limit
	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		seed           = 32'h9295;
		clock          = 1'b0;
		arst_n         = 1'b0;
		enabled        = 1'b0;
		read_cmd_in    = '0;
		write_cmd_in   = '0;
		restart_cmd_in = '0;
		response       = '0;
		errors         = 0;
		cycles         = 0;
		pushed         = 0;
		issued         = 0;
		returned       = 0;
		hold_issued    = 0;
		resp_count     = 0;
		host_wait      = 0;
		last_cls       = 0;
		last_pushed    = 1'b0;
		quiet          = 1'b0;
		host_hold      = 1'b0;
		bad_request    = 1'b0;
		bad_sent       = 1'b0;
		end_phase      = 1'b0;
		enabled_d      = 1'b0;
		empty_d        = '0;
		push_d         = '0;
		next_seq       = '0;
		err_model      = '0;
		resp_d1        = '0;
		resp_d2        = '0;
		skip           = '{0, 0, 0};
		occ            = '{0, 0, 0};
		quiet_chk      = 1'b0;
		quiet_val      = '0;
		dis_chk        = 1'b0;
		cmd_chk        = 1'b0;
		cmd_orphan     = 1'b0;
		hold_vio       = 1'b0;
		cmd_got        = '0;
		cmd_exp        = '0;
		seq_got        = '0;
		seq_exp        = '0;
		outstanding    = 0;
		max_skip       = 0;
		resp_got_all   = '0;
		resp_exp_all   = '0;
		err_got        = '0;
		err_exp        = '0;
		status_got     = '0;
		status_exp     = '0;
		end_chk        = 1'b0;
		err_final      = '0;

		repeat (4) @(posedge clock);
		arst_n <= 1'b1;
		quiet  <= 1'b1;
		repeat (3) @(posedge clock);
		quiet <= 1'b0;

		// Buffer commands with the unit disabled
		push_commands(WARM_CMDS, 1'b0);
		repeat (8) @(posedge clock);
		enabled <= 1'b1;

		// Mixed traffic under contention
		push_commands(RANDOM_CMDS, 1'b0);
		while (issued < pushed || returned != issued)
			@(posedge clock);

		bad_request <= 1'b1;
		while (!bad_sent)
			@(posedge clock);

		// Host holds its responses, credits run out
		host_hold <= 1'b1;
		push_commands(HOLD_CMDS, 1'b1);
		while (hold_issued < INITIAL_CREDITS)
			@(posedge clock);
		repeat (20) @(posedge clock);
		host_hold <= 1'b0;

		while (issued < NUM_CMDS || returned != issued)
			@(posedge clock);
		repeat (4) @(posedge clock);
		end_phase <= 1'b1;
		repeat (3) @(posedge clock);

		if (errors == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/capi_pkg.sv
hw/cmd_pkg.sv
hw/sync_fifo.sv
hw/cmd_arbiter.sv
hw/credit_tracker.sv
hw/cmd_issue.sv
hw/resp_router.sv
hw/command_unit.sv
tb/tb_command_unit.sv
